//--- logic/x86_prefix_pkg.sv
package x86_prefix_pkg;

   // Legacy prefix byte encodings.
   localparam logic [7:0] PFX_REPNE    = 8'hF2;
   localparam logic [7:0] PFX_REP      = 8'hF3;
   localparam logic [7:0] PFX_LOCK     = 8'hF0;
   localparam logic [7:0] PFX_ES       = 8'h26;
   localparam logic [7:0] PFX_CS       = 8'h2E;
   localparam logic [7:0] PFX_SS       = 8'h36;
   localparam logic [7:0] PFX_DS       = 8'h3E;
   localparam logic [7:0] PFX_FS       = 8'h64;
   localparam logic [7:0] PFX_GS       = 8'h65;
   localparam logic [7:0] PFX_OPSIZE   = 8'h66;
   localparam logic [7:0] PFX_ADDRSIZE = 8'h67;

   // Bit position of each prefix class in the flag vector.
   localparam int FLG_REP      = 0;
   localparam int FLG_LOCK     = 1;
   localparam int FLG_SEG      = 2;
   localparam int FLG_OPSIZE   = 3;
   localparam int FLG_ADDRSIZE = 4;
   localparam int NUM_FLAGS    = 5;

endpackage

//--- logic/decode_pkg.sv
package decode_pkg;

   // One byte of the instruction stream.
   typedef logic [7:0] insn_byte_t;

   // One bit per prefix class at the x86_prefix_pkg flag positions.
   typedef logic [x86_prefix_pkg::NUM_FLAGS-1:0] prefix_flags_t;

   // Number of leading prefixes in a window. Holds 0 to LANES for LANES up to 7.
   typedef logic [2:0] prefix_count_t;

   // Credit counter width.
   typedef logic [3:0] credit_t;

endpackage

//--- logic/decode_if.sv
// Window issue from the ingress buffer to the lanes and the summarizer.
interface issue_if #(
   parameter int LANES = 4
);
   logic                                 valid;
   decode_pkg::insn_byte_t [LANES-1:0]   bytes;
   logic                                 credit_ok; // Downstream has room for one more result.

   modport source (output valid, output bytes, input credit_ok);
   modport lane   (input valid, input bytes); // Each lane picks its own byte by index.
   modport sink   (input valid, output credit_ok);
endinterface

// Registered per-byte classification from the lanes to the summarizer.
interface class_if #(
   parameter int LANES = 4
);
   logic                          valid; // Driven by lane 0 only.
   decode_pkg::insn_byte_t        bytes     [LANES];
   logic                          is_prefix [LANES];
   decode_pkg::prefix_flags_t     flags     [LANES];

   modport lane (
      output valid,
      output bytes,
      output is_prefix,
      output flags
   );
   modport sink (
      input valid,
      input bytes,
      input is_prefix,
      input flags
   );
endinterface

//--- logic/window_ingress.sv
module window_ingress #(
   parameter int LANES      = 4,
   parameter int FIFO_DEPTH = 4
) (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                in_valid,
   input  decode_pkg::insn_byte_t [LANES-1:0]  in_window,
   output logic                                in_credit,
   issue_if.source                             iss
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   decode_pkg::insn_byte_t [LANES-1:0] mem [FIFO_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] fill;
   logic             full;
   logic             empty;
   logic             push;
   logic             pop;

   assign full  = (fill == CNT_W'(FIFO_DEPTH));
   assign empty = (fill == '0);
   assign push  = in_valid && !full;
   assign pop   = iss.credit_ok && !empty; // Oldest window leaves in this cycle.

   assign iss.valid = pop;
   assign iss.bytes = mem[rd_ptr];
   assign in_credit = pop; // The freed slot goes straight back upstream.

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_window;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
      end
   end

   // The upstream only sends against a credit it holds, so a full buffer sees no write.
   a_no_write_when_full : assert property (
      @(posedge clk) disable iff (!rst_n) in_valid |-> !full
   );

endmodule

//--- logic/prefix_lane.sv
module prefix_lane #(
   parameter int IDX = 0
) (
   input  logic     clk,
   input  logic     rst_n,
   issue_if.lane    iss,
   class_if.lane    cls
);

   decode_pkg::insn_byte_t    in_byte;
   decode_pkg::prefix_flags_t flags_d;
   decode_pkg::insn_byte_t    byte_q;
   logic                      is_prefix_q;
   decode_pkg::prefix_flags_t flags_q;

   assign in_byte = iss.bytes[IDX];

   always_comb begin
      flags_d = '0;
      case (in_byte)
         x86_prefix_pkg::PFX_REPNE,
         x86_prefix_pkg::PFX_REP:      flags_d[x86_prefix_pkg::FLG_REP]      = 1'b1;
         x86_prefix_pkg::PFX_LOCK:     flags_d[x86_prefix_pkg::FLG_LOCK]     = 1'b1;
         x86_prefix_pkg::PFX_ES,
         x86_prefix_pkg::PFX_CS,
         x86_prefix_pkg::PFX_SS,
         x86_prefix_pkg::PFX_DS,
         x86_prefix_pkg::PFX_FS,
         x86_prefix_pkg::PFX_GS:       flags_d[x86_prefix_pkg::FLG_SEG]      = 1'b1;
         x86_prefix_pkg::PFX_OPSIZE:   flags_d[x86_prefix_pkg::FLG_OPSIZE]   = 1'b1;
         x86_prefix_pkg::PFX_ADDRSIZE: flags_d[x86_prefix_pkg::FLG_ADDRSIZE] = 1'b1;
         default:                      flags_d = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (iss.valid) begin
         byte_q      <= in_byte;
         is_prefix_q <= |flags_d; // Exactly one class bit is set for a prefix.
         flags_q     <= flags_d;
      end
   end

   assign cls.bytes[IDX]     = byte_q;
   assign cls.is_prefix[IDX] = is_prefix_q;
   assign cls.flags[IDX]     = flags_q;

   // All lanes load on the same issue, so lane 0 carries valid for the window.
   if (IDX == 0) begin : g_valid
      logic valid_q;

      always_ff @(posedge clk) begin
         if (!rst_n) begin
            valid_q <= 1'b0;
         end else begin
            valid_q <= iss.valid;
         end
      end

      assign cls.valid = valid_q;
   end

endmodule

//--- logic/prefix_summarizer.sv
module prefix_summarizer #(
   parameter int LANES      = 4,
   parameter int FIFO_DEPTH = 4
) (
   input  logic                       clk,
   input  logic                       rst_n,
   issue_if.sink                      iss,
   class_if.sink                      cls,
   input  logic                       out_credit,
   output logic                       out_valid,
   output decode_pkg::prefix_count_t  out_count,
   output decode_pkg::prefix_flags_t  out_flags,
   output decode_pkg::insn_byte_t     out_opcode,
   output logic                       out_no_opcode
);

   // The downstream result buffer is sized like the ingress buffer.
   localparam decode_pkg::credit_t CREDIT_MAX = decode_pkg::credit_t'(FIFO_DEPTH);

   decode_pkg::credit_t       credits;
   logic                      found;
   decode_pkg::prefix_count_t count_d;
   decode_pkg::prefix_flags_t flags_d;
   decode_pkg::insn_byte_t    opcode_d;

   assign iss.credit_ok = (credits != '0);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         credits <= '0;
      end else begin
         case ({out_credit, iss.valid})
            2'b10:   credits <= credits + 1'b1;
            2'b01:   credits <= credits - 1'b1; // A window left the buffer against a credit.
            default: credits <= credits;
         endcase
      end
   end

   // Walk the lanes in program order and stop at the first byte that is not a prefix.
   always_comb begin
      found    = 1'b0;
      count_d  = decode_pkg::prefix_count_t'(LANES);
      flags_d  = '0;
      opcode_d = '0;
      for (int i = 0; i < LANES; i++) begin
         if (!found) begin
            if (cls.is_prefix[i]) begin
               flags_d = flags_d | cls.flags[i];
            end else begin
               found    = 1'b1;
               count_d  = decode_pkg::prefix_count_t'(i);
               opcode_d = cls.bytes[i];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= cls.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (cls.valid) begin
         out_count     <= count_d;
         out_flags     <= flags_d;
         out_opcode    <= opcode_d;
         out_no_opcode <= !found; // Window held prefixes only.
      end
   end

   // The downstream never returns more credits than it has result slots.
   a_credit_bound : assert property (
      @(posedge clk) disable iff (!rst_n) credits <= CREDIT_MAX
   );

endmodule

//--- logic/x86_prefix_decoder.sv
module x86_prefix_decoder #(
   parameter int LANES      = 4,
   parameter int FIFO_DEPTH = 4
) (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                in_valid,
   input  decode_pkg::insn_byte_t [LANES-1:0]  in_window,
   output logic                                in_credit,
   input  logic                                out_credit,
   output logic                                out_valid,
   output decode_pkg::prefix_count_t           out_count,
   output decode_pkg::prefix_flags_t           out_flags,
   output decode_pkg::insn_byte_t              out_opcode,
   output logic                                out_no_opcode
);

   issue_if #(.LANES(LANES)) iss_bus ();
   class_if #(.LANES(LANES)) cls_bus ();

   window_ingress #(
      .LANES      (LANES),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) ingress_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_window (in_window),
      .in_credit (in_credit),
      .iss       (iss_bus.source)
   );

   // One classifier per byte of the window.
   for (genvar i = 0; i < LANES; i++) begin : g_lane
      prefix_lane #(.IDX(i)) lane_inst (
         .clk   (clk),
         .rst_n (rst_n),
         .iss   (iss_bus.lane),
         .cls   (cls_bus.lane)
      );
   end

   prefix_summarizer #(
      .LANES      (LANES),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) summarizer_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .iss           (iss_bus.sink),
      .cls           (cls_bus.sink),
      .out_credit    (out_credit),
      .out_valid     (out_valid),
      .out_count     (out_count),
      .out_flags     (out_flags),
      .out_opcode    (out_opcode),
      .out_no_opcode (out_no_opcode)
   );

endmodule

//--- sim/decode_checker.sv
module decode_checker (
   input logic                      clk,
   input logic                      rst_n,
   input logic                      in_credit,
   input logic                      out_credit,
   input logic                      out_valid,
   input decode_pkg::prefix_count_t out_count,
   input decode_pkg::prefix_flags_t out_flags,
   input decode_pkg::insn_byte_t    out_opcode,
   input logic                      out_no_opcode
);
   timeunit 1ns;
   timeprecision 1ps;

   string                     exp_name   [$];
   decode_pkg::prefix_count_t exp_count  [$];
   decode_pkg::prefix_flags_t exp_flags  [$];
   decode_pkg::insn_byte_t    exp_opcode [$];
   logic                      exp_no_op  [$];

   int mismatch_count   = 0;
   int protocol_count   = 0;
   int results_seen     = 0;
   int credits_returned = 0;
   int windows_sent     = 0;
   int windows_issued   = 0;

   task automatic push_expected(input string name, input decode_pkg::prefix_count_t count,
                                input decode_pkg::prefix_flags_t flags,
                                input decode_pkg::insn_byte_t opcode, input logic no_op);
      exp_name.push_back(name);
      exp_count.push_back(count);
      exp_flags.push_back(flags);
      exp_opcode.push_back(opcode);
      exp_no_op.push_back(no_op);
      windows_sent++;
   endtask

   task automatic compare_field(input string name, input string field,
                                input logic [31:0] expected, input logic [31:0] actual);
      if (expected !== actual) begin
         $display("Mismatch %s %s: expected 0x%0h actual 0x%0h", name, field, expected, actual);
         mismatch_count++;
      end
   endtask

   task automatic final_check();
      if (exp_name.size() != 0) begin
         $display("%0d expected results never came out of the DUT", exp_name.size());
         protocol_count++;
      end
      if (windows_issued != windows_sent) begin
         $display("%0d windows were sent but %0d upstream credits came back",
                  windows_sent, windows_issued);
         protocol_count++;
      end
   endtask

   // The DUT takes a returned credit on the rising edge, and a window leaves the buffer there.
   always @(posedge clk) begin
      if (rst_n && out_credit) begin
         credits_returned++;
      end
      if (rst_n && in_credit) begin
         windows_issued++;
         if (windows_issued > windows_sent) begin
            $display("Upstream credit %0d came back with only %0d windows sent",
                     windows_issued, windows_sent);
            protocol_count++;
         end
      end
   end

   always @(negedge clk) begin
      string name;
      if (rst_n && out_valid) begin
         results_seen++;
         if (results_seen > credits_returned) begin
            $display("Result %0d came out with only %0d credits returned",
                     results_seen, credits_returned);
            protocol_count++;
         end
         if (results_seen > windows_issued) begin
            $display("Result %0d came out before its window left the buffer", results_seen);
            protocol_count++;
         end
         if (exp_name.size() == 0) begin
            $display("Result came out while no result was expected");
            protocol_count++;
         end else begin
            name = exp_name.pop_front();
            compare_field(name, "count", exp_count.pop_front(), out_count);
            compare_field(name, "flags", exp_flags.pop_front(), out_flags);
            compare_field(name, "opcode", exp_opcode.pop_front(), out_opcode);
            compare_field(name, "no_opcode", exp_no_op.pop_front(), out_no_opcode);
         end
      end
   end

endmodule

//--- sim/tb_top.sv
module tb_top;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int LANES          = 4;
   localparam int FIFO_DEPTH     = 4;
   localparam int NUM_ENTRIES    = 14;
   localparam int NUM_PASSES     = 2;
   localparam int TOTAL          = NUM_ENTRIES * NUM_PASSES;
   localparam int TIMEOUT_CYCLES = TOTAL * 40 + 200;

   localparam decode_pkg::prefix_flags_t F_REP  = 1 << x86_prefix_pkg::FLG_REP;
   localparam decode_pkg::prefix_flags_t F_LOCK = 1 << x86_prefix_pkg::FLG_LOCK;
   localparam decode_pkg::prefix_flags_t F_SEG  = 1 << x86_prefix_pkg::FLG_SEG;
   localparam decode_pkg::prefix_flags_t F_OPSZ = 1 << x86_prefix_pkg::FLG_OPSIZE;
   localparam decode_pkg::prefix_flags_t F_ADSZ = 1 << x86_prefix_pkg::FLG_ADDRSIZE;

   logic                               clk;
   logic                               rst_n;
   logic                               in_valid;
   decode_pkg::insn_byte_t [LANES-1:0] in_window;
   logic                               in_credit;
   logic                               out_credit;
   logic                               out_valid;
   decode_pkg::prefix_count_t          out_count;
   decode_pkg::prefix_flags_t          out_flags;
   decode_pkg::insn_byte_t             out_opcode;
   logic                               out_no_opcode;

   string                              t_name   [NUM_ENTRIES];
   decode_pkg::insn_byte_t [LANES-1:0] t_window [NUM_ENTRIES];
   decode_pkg::prefix_count_t          t_count  [NUM_ENTRIES];
   decode_pkg::prefix_flags_t          t_flags  [NUM_ENTRIES];
   decode_pkg::insn_byte_t             t_opcode [NUM_ENTRIES];
   logic                               t_no_op  [NUM_ENTRIES];
   int                                 n_entries = 0;
   logic [31:0]                        lfsr_state = 32'hee1ede94;

   x86_prefix_decoder #(.LANES(LANES), .FIFO_DEPTH(FIFO_DEPTH)) x86_prefix_decoder_inst (
      .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_window(in_window),
      .in_credit(in_credit), .out_credit(out_credit), .out_valid(out_valid),
      .out_count(out_count), .out_flags(out_flags), .out_opcode(out_opcode),
      .out_no_opcode(out_no_opcode)
   );

   decode_checker checker_inst (
      .clk(clk), .rst_n(rst_n), .in_credit(in_credit), .out_credit(out_credit),
      .out_valid(out_valid), .out_count(out_count), .out_flags(out_flags),
      .out_opcode(out_opcode), .out_no_opcode(out_no_opcode)
   );

   // Galois LFSR stepped once per bit taken.
   function automatic logic random_bit();
      logic b;
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) lfsr_state = lfsr_state ^ 32'h80200003;
      return b;
   endfunction

   // Bytes are given in program order, byte 0 first.
   task automatic add_entry(input string name, input decode_pkg::insn_byte_t b0, b1, b2, b3,
                            input int count, input decode_pkg::prefix_flags_t flags,
                            input decode_pkg::insn_byte_t opcode, input logic no_op);
      t_name[n_entries]   = name;
      t_window[n_entries] = {b3, b2, b1, b0};
      t_count[n_entries]  = decode_pkg::prefix_count_t'(count);
      t_flags[n_entries]  = flags;
      t_opcode[n_entries] = opcode;
      t_no_op[n_entries]  = no_op;
      n_entries++;
   endtask

   task automatic build_table();
      add_entry("rep_nop",      8'hF3, 8'h90, 8'h00, 8'h00, 1, F_REP,  8'h90, 1'b0);
      add_entry("opsize_mov",   8'h66, 8'h8B, 8'hC0, 8'h00, 1, F_OPSZ, 8'h8B, 1'b0);
      add_entry("cs_override",  8'h2E, 8'h8B, 8'h00, 8'h00, 1, F_SEG,  8'h8B, 1'b0);
      add_entry("lock_add",     8'hF0, 8'h01, 8'h02, 8'h03, 1, F_LOCK, 8'h01, 1'b0);
      add_entry("addrsize_lea", 8'h67, 8'h8D, 8'h04, 8'h24, 1, F_ADSZ, 8'h8D, 1'b0);
      add_entry("leading_only", 8'h66, 8'h90, 8'hF3, 8'h26, 1, F_OPSZ, 8'h90, 1'b0); // REP and ES come late.
      add_entry("es_fs_opsize", 8'h26, 8'h64, 8'h66, 8'h0F, 3, F_SEG | F_OPSZ, 8'h0F, 1'b0);
      add_entry("no_prefix",    8'h90, 8'hF3, 8'h66, 8'h26, 0, '0, 8'h90, 1'b0);
      add_entry("all_prefix",   8'hF2, 8'hF0, 8'h65, 8'h67, LANES,
                F_REP | F_LOCK | F_SEG | F_ADSZ, 8'h00, 1'b1);
      add_entry("repne_ss",     8'hF2, 8'h36, 8'hAE, 8'h00, 2, F_REP | F_SEG, 8'hAE, 1'b0);
      add_entry("ds_gs_lock",   8'h3E, 8'h65, 8'hF0, 8'hC3, 3, F_SEG | F_LOCK, 8'hC3, 1'b0);
      add_entry("zero_window",  8'h00, 8'h00, 8'h00, 8'h00, 0, '0, 8'h00, 1'b0);
      add_entry("near_miss",    8'hFF, 8'h66, 8'h67, 8'hF2, 0, '0, 8'hFF, 1'b0);
      add_entry("rep_movs",     8'h66, 8'h67, 8'hF3, 8'hA5, 3,
                F_OPSZ | F_ADSZ | F_REP, 8'hA5, 1'b0);
   endtask

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Timeout: not all results came out within %0d cycles", TIMEOUT_CYCLES);
      $display("Result: FAILED");
      $finish;
   end

   initial begin
      int  sent;
      int  results;
      int  up_credits;
      int  dn_owed;
      int  idx;
      logic credit_bit;
      logic hold_bit;
      rst_n      = 1'b0;
      in_valid   = 1'b0;
      in_window  = '0;
      out_credit = 1'b0;
      sent       = 0;
      results    = 0;
      up_credits = FIFO_DEPTH;
      dn_owed    = FIFO_DEPTH; // Downstream result slots not yet offered to the DUT.
      build_table();
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      while (results < TOTAL) begin
         @(negedge clk);
         in_valid   = 1'b0;
         out_credit = 1'b0;
         credit_bit = random_bit();
         hold_bit   = random_bit();
         if (out_valid) begin
            results++;
            dn_owed++; // The result is consumed at once, so its slot is free again.
         end
         if (dn_owed > 0 && credit_bit) begin
            out_credit = 1'b1;
            dn_owed--;
         end
         if (sent < TOTAL && up_credits > 0 && !hold_bit) begin
            idx       = sent % NUM_ENTRIES;
            in_window = t_window[idx];
            in_valid  = 1'b1;
            checker_inst.push_expected(t_name[idx], t_count[idx], t_flags[idx],
                                       t_opcode[idx], t_no_op[idx]);
            sent++;
            up_credits--;
         end
         if (in_credit) up_credits++; // That slot frees at the next rising edge.
      end
      repeat (4) @(posedge clk);
      checker_inst.final_check();
      $display("Errors: %0d mismatches, %0d protocol errors",
               checker_inst.mismatch_count, checker_inst.protocol_count);
      if (checker_inst.mismatch_count == 0 && checker_inst.protocol_count == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- compile.f
logic/x86_prefix_pkg.sv
logic/decode_pkg.sv
logic/decode_if.sv
logic/window_ingress.sv
logic/prefix_lane.sv
logic/prefix_summarizer.sv
logic/x86_prefix_decoder.sv
sim/decode_checker.sv
sim/tb_top.sv

//--- Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f compile.f -o tb_top
	./obj_dir/tb_top | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation failed."; \
		exit 1; \
	fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
